// File: files.f
common/eth_hdr_pkg.sv
common/axis_pkg.sv
hw/eth_tx/axis_skid_reg.sv
hw/eth_tx/eth_axis_tx.sv
hw/eth_arb_mux.sv
hw/eth_tx_top.sv
dv/tb_clk_gen.sv
dv/tb_eth_tx.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_tx -f files.f -o tb_sim \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/tb_eth_tx.sv
`default_nettype none

module tb_eth_tx
    import eth_hdr_pkg::*;
    import axis_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ten frames of at most 78 bytes at half rate need about 2000 cycles
    localparam int MAX_CYCLES = 20000;

    typedef logic [7:0] byte_q_t [$];

    logic       clk;
    logic       rst;
    logic [1:0] hdr_valid;
    logic [1:0] hdr_ready;
    eth_hdr_t   hdr [2];
    logic [1:0] pay_valid;
    logic [1:0] pay_ready;
    axis_beat_t pay [2];
    logic       m_valid;
    logic       m_ready;
    axis_beat_t m_beat;
    logic       busy;

    int         seed = 32'h21b98d89;
    int         cyc = 0;
    int         hdr_cyc [2];
    string      test_name;
    axis_beat_t exp_q [$];
    axis_beat_t got_q [$];
    int         got_cyc [$];

    tb_clk_gen u_clk (
        .clk(clk),
        .rst(rst)
    );

    eth_tx_top #(
        .PORTS(2)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .hdr_valid(hdr_valid),
        .hdr_ready(hdr_ready),
        .hdr      (hdr),
        .pay_valid(pay_valid),
        .pay_ready(pay_ready),
        .pay      (pay),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_beat   (m_beat),
        .busy     (busy)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing", cyc);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_beat(input string what, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            $display("ERROR [%s] %s: expected %02h last %b user %b, actual %02h last %b user %b",
                     test_name, what, exp.data, exp.last, exp.user,
                     act.data, act.last, act.user);
            $display("Something failed");
            $fatal(1, "beat mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR [%s] %s: expected %b, actual %b", test_name, what, exp, act);
            $display("Something failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_int(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("Something failed");
            $fatal(1, "count mismatch");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic eth_hdr_t make_hdr(input int port, input int idx);
        eth_hdr_t h;
        h.dest_mac  = {16'($random(seed)), 32'($random(seed))};
        // source MAC tells port and frame apart
        h.src_mac   = {24'h02_00_00, 8'(port), 16'(idx)};
        h.ethertype = 16'($random(seed));
        return h;
    endfunction

    function automatic byte_q_t rand_payload(input int len);
        byte_q_t q;
        for (int i = 0; i < len; i++) begin
            q.push_back(8'($random(seed)));
        end
        return q;
    endfunction

    // wire order is dest MAC, source MAC and ethertype, each high byte first
    function automatic void model_frame(input eth_hdr_t h, input byte_q_t data,
                                        input logic user);
        axis_beat_t b;
        byte_q_t    hb;
        for (int i = 5; i >= 0; i--) begin
            hb.push_back(h.dest_mac[8*i +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            hb.push_back(h.src_mac[8*i +: 8]);
        end
        hb.push_back(h.ethertype[15:8]);
        hb.push_back(h.ethertype[7:0]);
        foreach (hb[i]) begin
            b = '{data: hb[i], last: 1'b0, user: 1'b0};
            exp_q.push_back(b);
        end
        foreach (data[i]) begin
            b.data = data[i];
            b.last = (i == data.size() - 1);
            b.user = b.last && user;
            exp_q.push_back(b);
        end
    endfunction

    task automatic send_frame(input int port, input eth_hdr_t h, input byte_q_t data,
                              input logic user);
        axis_beat_t b;
        logic       fire;
        int         i;
        fire = 1'b0;
        hdr[port] = h;
        hdr_valid[port] = 1'b1;
        while (!fire) begin
            @(negedge clk);
            fire = hdr_ready[port];
            hdr_cyc[port] = cyc;
            step();
        end
        hdr_valid[port] = 1'b0;
        i = 0;
        while (i < data.size()) begin
            b.data = data[i];
            b.last = (i == data.size() - 1);
            b.user = b.last && user;
            pay[port] = b;
            pay_valid[port] = 1'b1;
            @(negedge clk);
            fire = pay_ready[port];
            step();
            if (fire) begin
                i++;
            end
        end
        pay_valid[port] = 1'b0;
    endtask

    // output sink with random m_ready when bp is set
    task automatic collect(input int n, input logic bp);
        axis_beat_t held;
        logic       stalled;
        stalled = 1'b0;
        while (got_q.size() < n) begin
            m_ready = bp ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
            if (stalled) begin
                check_bit("m_valid while stalled", 1'b1, m_valid);
                check_beat("beat while stalled", held, m_beat);
            end
            if (m_valid && m_ready) begin
                got_q.push_back(m_beat);
                got_cyc.push_back(cyc);
            end
            stalled = m_valid && !m_ready;
            held = m_beat;
            step();
        end
        m_ready = 1'b1;
    endtask

    task automatic check_stream();
        foreach (exp_q[i]) begin
            check_beat($sformatf("beat %0d", i), exp_q[i], got_q[i]);
        end
        // extra or duplicated beats would show up here
        repeat (3) begin
            @(negedge clk);
            check_bit("m_valid after frame", 1'b0, m_valid);
            step();
        end
        exp_q.delete();
        got_q.delete();
        got_cyc.delete();
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        check_bit("m_valid", 1'b0, m_valid);
        check_bit("hdr_ready[0]", 1'b0, hdr_ready[0]);
        check_bit("hdr_ready[1]", 1'b0, hdr_ready[1]);
        check_bit("pay_ready[0]", 1'b0, pay_ready[0]);
        check_bit("pay_ready[1]", 1'b0, pay_ready[1]);
        step();
    endtask

    task automatic test_single();
        eth_hdr_t h;
        byte_q_t  d;
        test_name = "single_frame";
        h = make_hdr(0, 1);
        d = rand_payload(20);
        model_frame(h, d, 1'b0);
        fork
            send_frame(0, h, d, 1'b0);
            collect(ETH_HDR_BYTES + 20, 1'b0);
        join
        check_int("cycle of first byte", hdr_cyc[0] + 1, got_cyc[0]);
        for (int i = 1; i < got_cyc.size(); i++) begin
            check_int($sformatf("cycle of beat %0d", i), got_cyc[i-1] + 1, got_cyc[i]);
        end
        check_stream();
    endtask

    // port 1 alone moves the round-robin pointer on to port 0
    task automatic test_back_pressure();
        eth_hdr_t hq [3];
        byte_q_t  dq [3];
        int       lens [3] = '{17, 64, 5};
        test_name = "back_pressure";
        for (int k = 0; k < 3; k++) begin
            hq[k] = make_hdr(1, k);
            dq[k] = rand_payload(lens[k]);
            model_frame(hq[k], dq[k], 1'b0);
        end
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    send_frame(1, hq[k], dq[k], 1'b0);
                end
            end
            collect(exp_q.size(), 1'b1);
        join
        check_stream();
    endtask

    // frame k comes from port k % 2 and both ports request all the time
    task automatic test_round_robin();
        eth_hdr_t hq [4];
        byte_q_t  dq [4];
        int       lens [4] = '{12, 30, 8, 45};
        test_name = "round_robin";
        for (int k = 0; k < 4; k++) begin
            hq[k] = make_hdr(k % 2, 16 + k);
            dq[k] = rand_payload(lens[k]);
            model_frame(hq[k], dq[k], 1'b0);
        end
        fork
            begin
                send_frame(0, hq[0], dq[0], 1'b0);
                send_frame(0, hq[2], dq[2], 1'b0);
            end
            begin
                send_frame(1, hq[1], dq[1], 1'b0);
                send_frame(1, hq[3], dq[3], 1'b0);
            end
            collect(exp_q.size(), 1'b1);
        join
        check_stream();
    endtask

    task automatic test_user_last();
        eth_hdr_t h;
        byte_q_t  d;
        test_name = "user_last";
        h = make_hdr(0, 32);
        d = rand_payload(10);
        model_frame(h, d, 1'b1);
        fork
            send_frame(0, h, d, 1'b1);
            collect(exp_q.size(), 1'b1);
        join
        foreach (got_q[i]) begin
            check_bit($sformatf("last on beat %0d", i), i == got_q.size() - 1, got_q[i].last);
            check_bit($sformatf("user on beat %0d", i), i == got_q.size() - 1, got_q[i].user);
        end
        check_stream();
    endtask

    task automatic test_busy();
        eth_hdr_t h;
        byte_q_t  d;
        test_name = "busy";
        h = make_hdr(0, 48);
        d = rand_payload(6);
        model_frame(h, d, 1'b0);
        fork
            send_frame(0, h, d, 1'b0);
            collect(exp_q.size(), 1'b0);
            begin
                @(negedge clk);
                while (!(hdr_valid[0] && hdr_ready[0])) begin
                    @(negedge clk);
                end
                @(negedge clk);
                check_bit("busy in flight", 1'b1, busy);
            end
        join
        @(negedge clk);
        check_bit("busy after frame", 1'b0, busy);
        step();
        check_stream();
    endtask

    initial begin
        hdr_valid = '0;
        pay_valid = '0;
        hdr[0]    = '0;
        hdr[1]    = '0;
        pay[0]    = '0;
        pay[1]    = '0;
        m_ready   = 1'b1;
        wait (rst == 1'b0);
        test_reset_state();
        test_single();
        test_back_pressure();
        test_round_robin();
        test_user_last();
        test_busy();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/eth_tx_top.sv
`default_nettype none

module eth_tx_top
    import eth_hdr_pkg::*;
    import axis_pkg::*;
#(
    parameter int PORTS = 2
) (
    input  wire              clk,
    input  wire              rst,

    input  wire [PORTS-1:0]  hdr_valid,
    output logic [PORTS-1:0] hdr_ready,
    input  wire eth_hdr_t    hdr [PORTS],
    input  wire [PORTS-1:0]  pay_valid,
    output logic [PORTS-1:0] pay_ready,
    input  wire axis_beat_t  pay [PORTS],

    output logic             m_valid,
    input  wire              m_ready,
    output axis_beat_t       m_beat,

    output logic             busy
);

    // granted frame between arbiter and framer
    logic       arb_hdr_valid;
    logic       arb_hdr_ready;
    eth_hdr_t   arb_hdr;
    logic       arb_pay_valid;
    logic       arb_pay_ready;
    axis_beat_t arb_pay;

    eth_arb_mux #(
        .PORTS(PORTS)
    ) u_arb (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .hdr          (hdr),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .pay          (pay),
        .out_hdr_valid(arb_hdr_valid),
        .out_hdr_ready(arb_hdr_ready),
        .out_hdr      (arb_hdr),
        .out_pay_valid(arb_pay_valid),
        .out_pay_ready(arb_pay_ready),
        .out_pay      (arb_pay)
    );

    eth_axis_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .hdr_valid(arb_hdr_valid),
        .hdr_ready(arb_hdr_ready),
        .hdr      (arb_hdr),
        .pay_valid(arb_pay_valid),
        .pay_ready(arb_pay_ready),
        .pay      (arb_pay),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_beat   (m_beat),
        .busy     (busy)
    );

endmodule

`default_nettype wire

// File: hw/eth_arb_mux.sv
`default_nettype none

module eth_arb_mux
    import eth_hdr_pkg::*;
    import axis_pkg::*;
#(
    parameter int PORTS = 2
) (
    input  wire              clk,
    input  wire              rst,

    // per-port sources
    input  wire [PORTS-1:0]  hdr_valid,
    output logic [PORTS-1:0] hdr_ready,
    input  wire eth_hdr_t    hdr [PORTS],
    input  wire [PORTS-1:0]  pay_valid,
    output logic [PORTS-1:0] pay_ready,
    input  wire axis_beat_t  pay [PORTS],

    // towards the framer
    output logic             out_hdr_valid,
    input  wire              out_hdr_ready,
    output eth_hdr_t         out_hdr,
    output logic             out_pay_valid,
    input  wire              out_pay_ready,
    output axis_beat_t       out_pay
);

    localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

    logic             active_reg;
    logic [PTR_W-1:0] grant_reg;
    logic [PTR_W-1:0] ptr_reg;

    logic [PTR_W-1:0] pick;
    logic [PTR_W-1:0] sel;
    logic             req_any;
    logic             hdr_fire;
    logic             last_fire;

    function automatic logic [PTR_W-1:0] wrap(input int i);
        return PTR_W'(i % PORTS);
    endfunction

    // first requester at or after the pointer
    always_comb begin
        req_any = 1'b0;
        pick    = ptr_reg;
        for (int k = 0; k < PORTS; k++) begin
            if (!req_any && hdr_valid[wrap(int'(ptr_reg) + k)]) begin
                req_any = 1'b1;
                pick    = wrap(int'(ptr_reg) + k);
            end
        end
    end

    // held grant during a frame, live pick while idle
    assign sel = active_reg ? grant_reg : pick;

    assign out_hdr       = hdr[sel];
    assign out_pay       = pay[sel];
    assign out_hdr_valid = !active_reg && req_any;
    assign out_pay_valid = active_reg && pay_valid[grant_reg];

    assign hdr_fire  = out_hdr_valid && out_hdr_ready;
    assign last_fire = out_pay_valid && out_pay_ready && out_pay.last;

    always_comb begin
        for (int i = 0; i < PORTS; i++) begin
            hdr_ready[i] = !active_reg && req_any && (pick == PTR_W'(i)) && out_hdr_ready;
            pay_ready[i] = active_reg && (grant_reg == PTR_W'(i)) && out_pay_ready;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_reg <= 1'b0;
            grant_reg  <= '0;
            ptr_reg    <= '0;
        end else if (hdr_fire) begin
            active_reg <= 1'b1;
            grant_reg  <= pick;
        end else if (last_fire) begin
            // next frame starts searching after this port
            active_reg <= 1'b0;
            ptr_reg    <= wrap(int'(grant_reg) + 1);
        end
    end

    // grant locks on the header port and holds until last payload beat
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        hdr_fire || (active_reg && !last_fire) |=> active_reg && grant_reg == $past(sel));

    // only one port may be handshaking at any time
    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({hdr_ready, pay_ready}));

endmodule

`default_nettype wire

// File: hw/eth_tx/eth_axis_tx.sv
`default_nettype none

module eth_axis_tx
    import eth_hdr_pkg::*;
    import axis_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    // parsed header
    input  wire        hdr_valid,
    output logic       hdr_ready,
    input  wire eth_hdr_t hdr,

    // payload stream
    input  wire        pay_valid,
    output logic       pay_ready,
    input  wire axis_beat_t pay,

    // framed output
    output logic       m_valid,
    input  wire        m_ready,
    output axis_beat_t m_beat,

    output logic       busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    localparam int PTR_W = $clog2(ETH_HDR_BYTES);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ETH_HDR_BYTES - 1);

    state_t           state_reg;
    state_t           state_next;
    logic [PTR_W-1:0] ptr_reg;
    logic [PTR_W-1:0] ptr_next;

    eth_hdr_t hdr_reg;
    logic     store_hdr;

    logic hdr_ready_reg;
    logic hdr_ready_next;
    logic pay_ready_reg;
    logic pay_ready_next;
    logic busy_reg;

    // beat towards the skid buffer
    axis_beat_t beat_int;
    logic       valid_int;
    logic       ready_early;
    logic       out_ready_q;

    assign hdr_ready = hdr_ready_reg;
    assign pay_ready = pay_ready_reg;
    assign busy      = busy_reg;

    // byte idx of the header in wire order
    function automatic logic [AXIS_DATA_W-1:0] hdr_byte(input eth_hdr_t h,
                                                        input logic [PTR_W-1:0] idx);
        return h[ETH_HDR_W - 1 - AXIS_DATA_W * int'(idx) -: AXIS_DATA_W];
    endfunction

    always_comb begin
        state_next     = state_reg;
        ptr_next       = ptr_reg;
        store_hdr      = 1'b0;
        hdr_ready_next = 1'b0;
        pay_ready_next = 1'b0;
        beat_int       = '0;
        valid_int      = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                ptr_next       = '0;
                hdr_ready_next = 1'b1;
                if (hdr_ready && hdr_valid) begin
                    store_hdr      = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next     = ST_HEADER;
                    // first byte straight from the input saves a cycle
                    if (out_ready_q) begin
                        valid_int     = 1'b1;
                        beat_int.data = hdr_byte(hdr, '0);
                        ptr_next      = PTR_W'(1);
                    end
                end
            end

            ST_HEADER: begin
                if (out_ready_q) begin
                    valid_int     = 1'b1;
                    beat_int.data = hdr_byte(hdr_reg, ptr_reg);
                    ptr_next      = ptr_reg + 1'b1;
                    if (ptr_reg == LAST_PTR) begin
                        pay_ready_next = ready_early;
                        state_next     = ST_PAYLOAD;
                    end
                end
            end

            ST_PAYLOAD: begin
                pay_ready_next = ready_early;
                beat_int       = pay;
                valid_int      = pay_valid && pay_ready;
                if (pay_valid && pay_ready && pay.last) begin
                    pay_ready_next = 1'b0;
                    hdr_ready_next = 1'b1;
                    state_next     = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg     <= ST_IDLE;
            ptr_reg       <= '0;
            hdr_ready_reg <= 1'b0;
            pay_ready_reg <= 1'b0;
            busy_reg      <= 1'b0;
            out_ready_q   <= 1'b0;
        end else begin
            state_reg     <= state_next;
            ptr_reg       <= ptr_next;
            hdr_ready_reg <= hdr_ready_next;
            pay_ready_reg <= pay_ready_next;
            busy_reg      <= (state_next != ST_IDLE);
            out_ready_q   <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= hdr;
        end
    end

    axis_skid_reg u_skid (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (valid_int),
        .in_beat    (beat_int),
        .ready_early(ready_early),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_beat     (m_beat)
    );

    // payload is only taken once all header bytes are queued
    a_no_early_pay: assert property (@(posedge clk) disable iff (rst)
        state_reg != ST_PAYLOAD |-> !pay_ready);

endmodule

`default_nettype wire

// File: hw/eth_tx/axis_skid_reg.sv
`default_nettype none

module axis_skid_reg
    import axis_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    // upstream beat, only presented after ready_early was high
    input  wire        in_valid,
    input  wire axis_beat_t in_beat,
    output logic       ready_early,

    // output stream
    output logic       m_valid,
    input  wire        m_ready,
    output axis_beat_t m_beat
);

    logic       out_valid;
    axis_beat_t out_beat;
    logic       temp_valid;
    axis_beat_t temp_beat;

    assign m_valid = out_valid;
    assign m_beat  = out_beat;

    // upstream may send next cycle if the output drains or one slot stays free
    assign ready_early = m_ready
                       | (!temp_valid && !out_valid)
                       | (!temp_valid && !in_valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else if (in_valid) begin
            if (m_ready || !out_valid) begin
                out_valid <= 1'b1;
            end else begin
                temp_valid <= 1'b1;
            end
        end else if (m_ready) begin
            // refill from temp, empties if nothing was parked
            out_valid  <= temp_valid;
            temp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (m_ready || !out_valid) begin
                out_beat <= in_beat;
            end else begin
                temp_beat <= in_beat;
            end
        end else if (m_ready) begin
            out_beat <= temp_beat;
        end
    end

    // stalled output holds its beat
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

// File: common/axis_pkg.sv
`default_nettype none

package axis_pkg;

    // byte-wide stream
    localparam int AXIS_DATA_W = 8;

    // one beat, valid and ready travel beside it
    typedef struct packed {
        logic [AXIS_DATA_W-1:0] data;
        logic                   last;
        // error flag of the frame, meaningful with last
        logic                   user;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: common/eth_hdr_pkg.sv
`default_nettype none

package eth_hdr_pkg;

    // field widths of the parsed header
    localparam int MAC_W   = 48;
    localparam int ETYPE_W = 16;

    // total header width in bits
    localparam int ETH_HDR_W = 2 * MAC_W + ETYPE_W;

    // header bytes on the wire
    localparam int ETH_HDR_BYTES = 14;

    // msb first in wire order, so byte k of the frame is the k-th byte from the top
    typedef struct packed {
        logic [MAC_W-1:0]   dest_mac;
        logic [MAC_W-1:0]   src_mac;
        logic [ETYPE_W-1:0] ethertype;
    } eth_hdr_t;

endpackage

`default_nettype wire
